// File: bench/core_trace.txt
# test <name>, mem <byte address> <word>, store <byte address> <data>, all hex
# stop <halt|illegal>; stores are listed in the order the core makes them
test alu
mem 00000000 06400093  # addi x1, x0, 100
mem 00000004 ff900113  # addi x2, x0, -7
mem 00000008 002081b3  # add x3, x1, x2
mem 0000000c 40208233  # sub x4, x1, x2
mem 00000010 40115293  # srai x5, x2, 1
mem 00000014 01c15313  # srli x6, x2, 28
mem 00000018 00309393  # slli x7, x1, 3
mem 0000001c 00112433  # slt x8, x2, x1
mem 00000020 001134b3  # sltu x9, x2, x1
mem 00000024 0020c533  # xor x10, x1, x2
mem 00000028 0ff17613  # andi x12, x2, 0xff
mem 0000002c 10302023
mem 00000030 10402223
mem 00000034 10502423
mem 00000038 10602623
mem 0000003c 10702823
mem 00000040 10802a23
mem 00000044 10902c23
mem 00000048 10a02e23
mem 0000004c 12c02023  # sw x12, 0x120(x0)
mem 00000050 00000073  # ecall
store 00000100 0000005d
store 00000104 0000006b
store 00000108 fffffffc
store 0000010c 0000000f
store 00000110 00000320
store 00000114 00000001
store 00000118 00000000
store 0000011c ffffff9d
store 00000120 000000f9
stop halt
test upper_jump
mem 00000000 123450b7  # lui x1, 0x12345
mem 00000004 00001117  # auipc x2, 1
mem 00000008 10102023
mem 0000000c 10202223
mem 00000010 00c001ef  # jal x3, +12
mem 0000001c 10302423
mem 00000020 01d18267  # jalr x4, 0x1d(x3), odd target
mem 00000030 10402623
mem 00000034 00100073  # ebreak
store 00000100 12345000
store 00000104 00001004
store 00000108 00000014
store 0000010c 00000024
stop halt
test branch
mem 00000000 fff00093  # addi x1, x0, -1
mem 00000004 00100113  # addi x2, x0, 1
mem 00000008 05a00193  # addi x3, x0, 0x5a
mem 0000000c 20208063  # beq x1, x2, not taken
mem 00000010 00108463  # beq x1, x1, +8
mem 00000018 10302023
mem 0000001c 20109063  # bne x1, x1, not taken
mem 00000020 00209463
mem 00000028 10102223
mem 0000002c 20114063  # blt x2, x1, not taken
mem 00000030 0020c463
mem 00000038 10202423
mem 0000003c 2020d063  # bge x1, x2, not taken
mem 00000040 00115463
mem 00000048 10302623
mem 0000004c 2020e063  # bltu x1, x2, not taken
mem 00000050 00116463
mem 00000058 10102823
mem 0000005c 20117063  # bgeu x2, x1, not taken
mem 00000060 0020f463
mem 00000068 10202a23
mem 0000006c 00000073
store 00000100 0000005a
store 00000104 ffffffff
store 00000108 00000001
store 0000010c 0000005a
store 00000110 ffffffff
store 00000114 00000001
stop halt
test load_store
mem 00000000 18000293  # addi x5, x0, 0x180
mem 00000004 0002a083  # lw x1, 0(x5)
mem 00000008 0042a103  # lw x2, 4(x5)
mem 0000000c 0422a023  # sw x2, 0x40(x5)
mem 00000010 0412a223  # sw x1, 0x44(x5)
mem 00000014 0002a003  # lw x0, 0(x5)
mem 00000018 0402a423  # sw x0, 0x48(x5)
mem 0000001c 00000073
mem 00000180 cafef00d
mem 00000184 80000001
store 000001c0 80000001
store 000001c4 cafef00d
store 000001c8 00000000
stop halt
test illegal_op
mem 00000000 03300093  # addi x1, x0, 0x33
mem 00000004 10102023
mem 00000008 0000000b  # custom-0, not decoded
mem 0000000c 10102223
mem 00000010 00000073
store 00000100 00000033
stop illegal

// File: project.f
logic/rv_isa_pkg.sv
logic/core_ctrl_pkg.sv
logic/register_file.sv
logic/alu.sv
logic/immediate_extender.sv
logic/dataflow.sv
logic/control_unit.sv
logic/rv_core.sv
bench/rv_core_tb.sv

// File: Makefile
# Verilator build and run of the core testbench

SIM = obj_dir/rv_core_sim

all:
	verilator --binary --timing --timescale 1ns/10ps -f project.f --top-module rv_core_tb -o rv_core_sim
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "^STATUS: PASS$$"

lint:
	verilator --lint-only --timing --timescale 1ns/10ps -f project.f --top-module rv_core

clean:
	rm -rf obj_dir

.PHONY: all lint clean

// File: bench/rv_core_tb.sv
// RV32I core testbench
`timescale 1ns/10ps

module rv_core_tb;

  localparam string trace_path = "bench/core_trace.txt";

  logic              clock;
  logic              rst;
  rv_isa_pkg::word_t rd_data;
  rv_isa_pkg::word_t mem_addr;
  rv_isa_pkg::word_t wr_data;
  logic              mem_rd;
  logic              mem_wr;
  logic              halted;
  logic              illegal;

  // 1 KB word memory
  rv_isa_pkg::word_t mem [0:255];

  // Trace contents tagged by test index
  string             test_name [$];
  bit                test_illegal [$];
  int                image_test [$];
  rv_isa_pkg::word_t image_addr [$];
  rv_isa_pkg::word_t image_data [$];
  int                store_test [$];
  rv_isa_pkg::word_t store_addr [$];
  rv_isa_pkg::word_t store_data [$];

  // Stores still due in the running test
  rv_isa_pkg::word_t exp_addr [$];
  rv_isa_pkg::word_t exp_data [$];

  int    errors = 0;
  int    passed = 0;
  int    failed = 0;
  int    limit_ns = 0;
  string current_test = "none";

  rv_core #(
    .reset_vector (32'h0000_0000)
  ) rv_core_i (
    .clock    (clock),
    .rst      (rst),
    .rd_data  (rd_data),
    .mem_addr (mem_addr),
    .wr_data  (wr_data),
    .mem_rd   (mem_rd),
    .mem_wr   (mem_wr),
    .halted   (halted),
    .illegal  (illegal)
  );

  // Reads answer in the same cycle
  assign rd_data = mem_rd ? mem[mem_addr[9:2]] : '0;

  initial begin
    clock = 1'b0;
    forever begin
      #50 clock = ~clock;
    end
  end

  task automatic check_word(input string name, input rv_isa_pkg::word_t expected,
                            input rv_isa_pkg::word_t actual);
    if (actual !== expected) begin
      $display("ERR %s expected %08h actual %08h in test %s", name, expected, actual,
               current_test);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERR %s expected %0h actual %0h in test %s", name, expected, actual,
               current_test);
      errors++;
    end
  endtask

  task automatic read_trace();
    int                fd;
    int                count;
    string             line;
    string             key;
    string             word;
    rv_isa_pkg::word_t a;
    rv_isa_pkg::word_t d;
    fd = $fopen(trace_path, "r");
    if (fd == 0) begin
      $display("Cannot open the trace file %s", trace_path);
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      key = "";
      count = $fgets(line, fd);
      count = $sscanf(line, "%s", key);
      if (count < 1 || key.getc(0) == "#") begin
        continue;
      end
      if (key == "test") begin
        count = $sscanf(line, "%s %s", key, word);
        test_name.push_back(word);
        test_illegal.push_back(1'b0);
      end else if (key == "mem") begin
        count = $sscanf(line, "%s %h %h", key, a, d);
        image_test.push_back(test_name.size() - 1);
        image_addr.push_back(a);
        image_data.push_back(d);
      end else if (key == "store") begin
        count = $sscanf(line, "%s %h %h", key, a, d);
        store_test.push_back(test_name.size() - 1);
        store_addr.push_back(a);
        store_data.push_back(d);
      end else if (key == "stop") begin
        count = $sscanf(line, "%s %s", key, word);
        test_illegal[test_name.size() - 1] = (word == "illegal");
      end else begin
        $display("Unknown trace line: %s", line);
        errors++;
      end
    end
    $fclose(fd);
  endtask

  task automatic record_store();
    mem[mem_addr[9:2]] = wr_data;
    if (exp_addr.size() == 0) begin
      $display("Unexpected store of %08h to %08h in test %s", wr_data, mem_addr, current_test);
      errors++;
    end else begin
      check_word("mem_addr", exp_addr.pop_front(), mem_addr);
      check_word("wr_data", exp_data.pop_front(), wr_data);
    end
  endtask

  task automatic run_test(input int t);
    int start_errors;
    start_errors = errors;
    current_test = test_name[t];
    exp_addr.delete();
    exp_data.delete();
    for (int i = 0; i < store_test.size(); i++) begin
      if (store_test[i] == t) begin
        exp_addr.push_back(store_addr[i]);
        exp_data.push_back(store_data[i]);
      end
    end
    @(negedge clock);
    rst = 1'b1;
    // Fill words have opcode low bits 00 and decode as illegal
    for (int i = 0; i < 256; i++) begin
      mem[i[7:0]] = 32'hbad0_0000 + (i * 4);
    end
    for (int i = 0; i < image_test.size(); i++) begin
      if (image_test[i] == t) begin
        mem[image_addr[i][9:2]] = image_data[i];
      end
    end
    repeat (4) @(negedge clock);
    rst = 1'b0;
    while (halted !== 1'b1) begin
      @(negedge clock);
      if (mem_wr === 1'b1) begin
        record_store();
      end
    end
    check_flag("illegal", test_illegal[t], illegal);
    // No memory reads or writes once stopped
    repeat (2) begin
      @(negedge clock);
      if (mem_wr !== 1'b0 || mem_rd !== 1'b0) begin
        $display("Memory access after the stop in test %s", current_test);
        errors++;
      end
    end
    if (exp_addr.size() != 0) begin
      $display("%0d expected stores never happened in test %s", exp_addr.size(),
               current_test);
      errors++;
    end
    if (errors == start_errors) begin
      passed++;
      $display("Test %s: ok", current_test);
    end else begin
      failed++;
      $display("Test %s: failed with %0d errors", current_test, errors - start_errors);
    end
  endtask

  // Watchdog scaled by the program size
  initial begin
    wait (limit_ns > 0);
    #(limit_ns);
    $display("Timeout after %0d ns, test %s never stopped", limit_ns, current_test);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    rst = 1'b1;
    read_trace();
    limit_ns = image_test.size() * 5 * 20 * 100;
    for (int t = 0; t < test_name.size(); t++) begin
      run_test(t);
    end
    $display("Tests passed %0d failed %0d", passed, failed);
    if (errors == 0 && failed == 0 && test_name.size() > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: logic/rv_core.sv
// RV32I multicycle core
`timescale 1ns/10ps

module rv_core #(
  parameter rv_isa_pkg::word_t reset_vector = '0
) (
  input  logic              clock,
  input  logic              rst,
  input  rv_isa_pkg::word_t rd_data,
  output rv_isa_pkg::word_t mem_addr,
  output rv_isa_pkg::word_t wr_data,
  output logic              mem_rd,
  output logic              mem_wr,
  output logic              halted,
  output logic              illegal
);

  // Control unit to datapath
  logic                    ir_en;
  logic                    pc_en;
  logic                    pc_src;
  logic                    alua_src;
  logic                    alub_src;
  core_ctrl_pkg::alu_sel_t alu_sel;
  logic                    alu_sub;
  logic                    alu_arith;
  logic                    jalr_sel;
  core_ctrl_pkg::wr_src_t  wr_reg_src;
  logic                    wr_reg_en;
  logic                    mem_addr_src;

  // Datapath to control unit
  rv_isa_pkg::opcode_t opcode;
  rv_isa_pkg::funct3_t funct3;
  logic [6:0]          funct7;
  logic                zero;
  logic                negative;
  logic                carry_out;
  logic                overflow;

  control_unit control_unit_i (
    .clock        (clock),
    .rst          (rst),
    .opcode       (opcode),
    .funct3       (funct3),
    .funct7       (funct7),
    .zero         (zero),
    .negative     (negative),
    .carry_out    (carry_out),
    .overflow     (overflow),
    .ir_en        (ir_en),
    .pc_en        (pc_en),
    .pc_src       (pc_src),
    .alua_src     (alua_src),
    .alub_src     (alub_src),
    .alu_sel      (alu_sel),
    .alu_sub      (alu_sub),
    .alu_arith    (alu_arith),
    .jalr_sel     (jalr_sel),
    .wr_reg_src   (wr_reg_src),
    .wr_reg_en    (wr_reg_en),
    .mem_addr_src (mem_addr_src),
    .mem_rd       (mem_rd),
    .mem_wr       (mem_wr),
    .halted       (halted),
    .illegal      (illegal)
  );

  dataflow #(
    .reset_vector (reset_vector)
  ) dataflow_i (
    .clock        (clock),
    .rst          (rst),
    .rd_data      (rd_data),
    .wr_data      (wr_data),
    .mem_addr     (mem_addr),
    .alua_src     (alua_src),
    .alub_src     (alub_src),
    .alu_sel      (alu_sel),
    .alu_sub      (alu_sub),
    .alu_arith    (alu_arith),
    .jalr_sel     (jalr_sel),
    .pc_src       (pc_src),
    .pc_en        (pc_en),
    .wr_reg_src   (wr_reg_src),
    .wr_reg_en    (wr_reg_en),
    .ir_en        (ir_en),
    .mem_addr_src (mem_addr_src),
    .opcode       (opcode),
    .funct3       (funct3),
    .funct7       (funct7),
    .zero         (zero),
    .negative     (negative),
    .carry_out    (carry_out),
    .overflow     (overflow)
  );

endmodule

// File: logic/control_unit.sv
// Multicycle control unit
`timescale 1ns/10ps

module control_unit (
  input  logic                    clock,
  input  logic                    rst,
  input  rv_isa_pkg::opcode_t     opcode,
  input  rv_isa_pkg::funct3_t     funct3,
  input  logic [6:0]              funct7,
  input  logic                    zero,
  input  logic                    negative,
  input  logic                    carry_out,
  input  logic                    overflow,
  output logic                    ir_en,
  output logic                    pc_en,
  output logic                    pc_src,
  output logic                    alua_src,
  output logic                    alub_src,
  output core_ctrl_pkg::alu_sel_t alu_sel,
  output logic                    alu_sub,
  output logic                    alu_arith,
  output logic                    jalr_sel,
  output core_ctrl_pkg::wr_src_t  wr_reg_src,
  output logic                    wr_reg_en,
  output logic                    mem_addr_src,
  output logic                    mem_rd,
  output logic                    mem_wr,
  output logic                    halted,
  output logic                    illegal
);

  core_ctrl_pkg::core_state_t state;
  core_ctrl_pkg::core_state_t next_state;
  logic                       alu_op;
  logic                       mem_op;
  logic                       known_op;
  logic                       signed_lt;
  logic                       taken;

  assign alu_op = (opcode == rv_isa_pkg::op_op) || (opcode == rv_isa_pkg::op_op_imm);
  assign mem_op = (opcode == rv_isa_pkg::op_load) || (opcode == rv_isa_pkg::op_store);
  assign known_op = alu_op || mem_op
                 || (opcode == rv_isa_pkg::op_lui) || (opcode == rv_isa_pkg::op_auipc)
                 || (opcode == rv_isa_pkg::op_jal) || (opcode == rv_isa_pkg::op_jalr)
                 || (opcode == rv_isa_pkg::op_branch);

  // ALU function follows funct3 for register and immediate ops, else add
  assign alu_sel   = alu_op ? funct3 : core_ctrl_pkg::alu_add;
  assign alu_arith = alu_op && funct7[5];
  // OP_IMM never subtracts, its funct7 bits belong to the immediate
  assign alu_sub = (opcode == rv_isa_pkg::op_branch)
                || ((opcode == rv_isa_pkg::op_op) && (funct3 == rv_isa_pkg::f3_add_sub)
                    && funct7[5]);

  // Branch decision from the rs1 - rs2 flags
  assign signed_lt = negative ^ overflow;

  always_comb begin
    case (funct3)
      rv_isa_pkg::f3_beq:  taken = zero;
      rv_isa_pkg::f3_bne:  taken = !zero;
      rv_isa_pkg::f3_blt:  taken = signed_lt;
      rv_isa_pkg::f3_bge:  taken = !signed_lt;
      rv_isa_pkg::f3_bltu: taken = !carry_out;
      rv_isa_pkg::f3_bgeu: taken = carry_out;
      default:             taken = 1'b0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      state   <= core_ctrl_pkg::st_fetch;
      illegal <= 1'b0;
    end else begin
      state <= next_state;
      if (state == core_ctrl_pkg::st_decode && !known_op
          && opcode != rv_isa_pkg::op_system) begin
        illegal <= 1'b1;
      end
    end
  end

  assign halted = (state == core_ctrl_pkg::st_halt);

  always_comb begin
    next_state   = state;
    ir_en        = 1'b0;
    pc_en        = 1'b0;
    pc_src       = 1'b0;
    alua_src     = 1'b0;
    alub_src     = 1'b0;
    jalr_sel     = 1'b0;
    wr_reg_src   = core_ctrl_pkg::wr_alu;
    wr_reg_en    = 1'b0;
    mem_addr_src = 1'b0;
    mem_rd       = 1'b0;
    mem_wr       = 1'b0;
    case (state)
      core_ctrl_pkg::st_fetch: begin
        mem_rd     = 1'b1;
        ir_en      = 1'b1;
        next_state = core_ctrl_pkg::st_decode;
      end
      core_ctrl_pkg::st_decode: begin
        // SYSTEM and unknown opcodes both stop the core
        next_state = known_op ? core_ctrl_pkg::st_execute : core_ctrl_pkg::st_halt;
      end
      core_ctrl_pkg::st_execute: begin
        next_state = core_ctrl_pkg::st_fetch;
        case (opcode)
          rv_isa_pkg::op_op: begin
            wr_reg_en = 1'b1;
            pc_en     = 1'b1;
          end
          rv_isa_pkg::op_op_imm: begin
            alub_src  = 1'b1;
            wr_reg_en = 1'b1;
            pc_en     = 1'b1;
          end
          rv_isa_pkg::op_lui: begin
            wr_reg_src = core_ctrl_pkg::wr_imm;
            wr_reg_en  = 1'b1;
            pc_en      = 1'b1;
          end
          rv_isa_pkg::op_auipc: begin
            alua_src  = 1'b1;
            alub_src  = 1'b1;
            wr_reg_en = 1'b1;
            pc_en     = 1'b1;
          end
          rv_isa_pkg::op_jal, rv_isa_pkg::op_jalr: begin
            jalr_sel   = (opcode == rv_isa_pkg::op_jalr);
            wr_reg_src = core_ctrl_pkg::wr_pc4;
            wr_reg_en  = 1'b1;
            pc_src     = 1'b1;
            pc_en      = 1'b1;
          end
          rv_isa_pkg::op_branch: begin
            pc_src = taken;
            pc_en  = 1'b1;
          end
          default: begin
            // Load or store, address settles on the ALU
            alub_src   = 1'b1;
            next_state = core_ctrl_pkg::st_memory;
          end
        endcase
      end
      core_ctrl_pkg::st_memory: begin
        alub_src     = 1'b1;
        mem_addr_src = 1'b1;
        pc_en        = 1'b1;
        next_state   = core_ctrl_pkg::st_fetch;
        if (opcode == rv_isa_pkg::op_load) begin
          mem_rd     = 1'b1;
          wr_reg_src = core_ctrl_pkg::wr_mem;
          wr_reg_en  = 1'b1;
        end else begin
          mem_wr = 1'b1;
        end
      end
      default: begin
        next_state = core_ctrl_pkg::st_halt;
      end
    endcase
  end

endmodule

// File: logic/dataflow.sv
// Multicycle core datapath
`timescale 1ns/10ps

module dataflow #(
  parameter rv_isa_pkg::word_t reset_vector = '0
) (
  input  logic                    clock,
  input  logic                    rst,
  input  rv_isa_pkg::word_t       rd_data,
  output rv_isa_pkg::word_t       wr_data,
  output rv_isa_pkg::word_t       mem_addr,
  input  logic                    alua_src,
  input  logic                    alub_src,
  input  core_ctrl_pkg::alu_sel_t alu_sel,
  input  logic                    alu_sub,
  input  logic                    alu_arith,
  input  logic                    jalr_sel,
  input  logic                    pc_src,
  input  logic                    pc_en,
  input  core_ctrl_pkg::wr_src_t  wr_reg_src,
  input  logic                    wr_reg_en,
  input  logic                    ir_en,
  input  logic                    mem_addr_src,
  output rv_isa_pkg::opcode_t     opcode,
  output rv_isa_pkg::funct3_t     funct3,
  output logic [6:0]              funct7,
  output logic                    zero,
  output logic                    negative,
  output logic                    carry_out,
  output logic                    overflow
);

  rv_isa_pkg::word_t     pc;
  rv_isa_pkg::word_t     next_pc;
  rv_isa_pkg::word_t     pc_plus_4;
  rv_isa_pkg::word_t     target;
  rv_isa_pkg::word_t     target_base;
  rv_isa_pkg::instr_t    ir;
  rv_isa_pkg::reg_addr_t rs1_addr;
  rv_isa_pkg::reg_addr_t rs2_addr;
  rv_isa_pkg::reg_addr_t rd_addr;
  rv_isa_pkg::word_t     rs1;
  rv_isa_pkg::word_t     rs2;
  rv_isa_pkg::word_t     rd_value;
  rv_isa_pkg::word_t     immediate;
  rv_isa_pkg::word_t     alu_a;
  rv_isa_pkg::word_t     alu_b;
  rv_isa_pkg::word_t     alu_y;

  // Instruction register, loaded at the end of FETCH
  always_ff @(posedge clock) begin
    if (ir_en) begin
      ir <= rd_data;
    end
  end

  assign rs1_addr = ir[19:15];
  assign rs2_addr = ir[24:20];
  assign rd_addr  = ir[11:7];

  // Write-back source
  always_comb begin
    case (wr_reg_src)
      core_ctrl_pkg::wr_mem: rd_value = rd_data;
      core_ctrl_pkg::wr_pc4: rd_value = pc_plus_4;
      core_ctrl_pkg::wr_imm: rd_value = immediate;
      default:               rd_value = alu_y;
    endcase
  end

  register_file register_file_i (
    .clock         (clock),
    .rst           (rst),
    .write_enable  (wr_reg_en),
    .read_address1 (rs1_addr),
    .read_address2 (rs2_addr),
    .write_address (rd_addr),
    .write_data    (rd_value),
    .read_data1    (rs1),
    .read_data2    (rs2)
  );

  immediate_extender immediate_extender_i (
    .instruction (ir),
    .immediate   (immediate)
  );

  assign alu_a = alua_src ? pc : rs1;
  assign alu_b = alub_src ? immediate : rs2;

  alu alu_i (
    .a          (alu_a),
    .b          (alu_b),
    .alu_sel    (alu_sel),
    .sub        (alu_sub),
    .arithmetic (alu_arith),
    .y          (alu_y),
    .zero       (zero),
    .negative   (negative),
    .carry_out  (carry_out),
    .overflow   (overflow)
  );

  // Branch and jump target, JALR clears bit 0
  assign target_base = jalr_sel ? rs1 : pc;
  assign target = (target_base + immediate) & {{31{1'b1}}, ~jalr_sel};

  assign pc_plus_4 = pc + 32'd4;
  assign next_pc = pc_src ? target : pc_plus_4;

  always_ff @(posedge clock) begin
    if (rst) begin
      pc <= reset_vector;
    end else if (pc_en) begin
      pc <= next_pc;
    end
  end

  assign mem_addr = mem_addr_src ? alu_y : pc;
  assign wr_data  = rs2;

  // Fields for the control unit
  assign opcode = ir[6:0];
  assign funct3 = ir[14:12];
  assign funct7 = ir[31:25];

endmodule

// File: logic/immediate_extender.sv
// Immediate extender
`timescale 1ns/10ps

module immediate_extender (
  input  rv_isa_pkg::instr_t instruction,
  output rv_isa_pkg::word_t  immediate
);

  rv_isa_pkg::opcode_t opcode;

  assign opcode = instruction[6:0];

  always_comb begin
    case (opcode)
      // U format
      rv_isa_pkg::op_lui, rv_isa_pkg::op_auipc:
        immediate = {instruction[31:12], 12'b0};
      // J format
      rv_isa_pkg::op_jal:
        immediate = {{12{instruction[31]}}, instruction[19:12], instruction[20],
                     instruction[30:21], 1'b0};
      // B format
      rv_isa_pkg::op_branch:
        immediate = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                     instruction[11:8], 1'b0};
      // S format
      rv_isa_pkg::op_store:
        immediate = {{21{instruction[31]}}, instruction[30:25], instruction[11:7]};
      // I format for ALU immediates, loads and JALR
      default:
        immediate = {{21{instruction[31]}}, instruction[30:20]};
    endcase
  end

endmodule

// File: logic/alu.sv
// Integer ALU
`timescale 1ns/10ps

module alu (
  input  rv_isa_pkg::word_t       a,
  input  rv_isa_pkg::word_t       b,
  input  core_ctrl_pkg::alu_sel_t alu_sel,
  input  logic                    sub,
  input  logic                    arithmetic,
  output rv_isa_pkg::word_t       y,
  output logic                    zero,
  output logic                    negative,
  output logic                    carry_out,
  output logic                    overflow
);

  rv_isa_pkg::word_t b_eff;
  rv_isa_pkg::word_t sum;
  logic [4:0]        shamt;

  // Subtract as a plus inverted b plus one
  assign b_eff = sub ? ~b : b;
  assign {carry_out, sum} = {1'b0, a} + {1'b0, b_eff} + {32'b0, sub};
  assign shamt = b[4:0];

  // Flags of the add/subtract path, used for branch decisions
  assign zero     = (sum == '0);
  assign negative = sum[31];
  assign overflow = (a[31] == b_eff[31]) && (sum[31] != a[31]);

  always_comb begin
    case (alu_sel)
      core_ctrl_pkg::alu_add:  y = sum;
      core_ctrl_pkg::alu_sll:  y = a << shamt;
      core_ctrl_pkg::alu_slt:  y = {31'b0, $signed(a) < $signed(b)};
      core_ctrl_pkg::alu_sltu: y = {31'b0, a < b};
      core_ctrl_pkg::alu_xor:  y = a ^ b;
      core_ctrl_pkg::alu_sr: begin
        if (arithmetic) begin
          y = $signed(a) >>> shamt;
        end else begin
          y = a >> shamt;
        end
      end
      core_ctrl_pkg::alu_or:   y = a | b;
      default:                 y = a & b;
    endcase
  end

endmodule

// File: logic/register_file.sv
// Integer register file
`timescale 1ns/10ps

module register_file (
  input  logic                  clock,
  input  logic                  rst,
  input  logic                  write_enable,
  input  rv_isa_pkg::reg_addr_t read_address1,
  input  rv_isa_pkg::reg_addr_t read_address2,
  input  rv_isa_pkg::reg_addr_t write_address,
  input  rv_isa_pkg::word_t     write_data,
  output rv_isa_pkg::word_t     read_data1,
  output rv_isa_pkg::word_t     read_data2
);

  // x1 to x31, x0 has no storage
  rv_isa_pkg::word_t regs [1:31];

  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && write_address != '0) begin
      regs[write_address] <= write_data;
    end
  end

  assign read_data1 = (read_address1 == '0) ? '0 : regs[read_address1];
  assign read_data2 = (read_address2 == '0) ? '0 : regs[read_address2];

endmodule

// File: logic/core_ctrl_pkg.sv
// Core control encodings
package core_ctrl_pkg;

  // ALU function select, same order as the RV32I funct3 field
  typedef logic [2:0] alu_sel_t;

  localparam alu_sel_t alu_add  = 3'b000;
  localparam alu_sel_t alu_sll  = 3'b001;
  localparam alu_sel_t alu_slt  = 3'b010;
  localparam alu_sel_t alu_sltu = 3'b011;
  localparam alu_sel_t alu_xor  = 3'b100;
  localparam alu_sel_t alu_sr   = 3'b101;
  localparam alu_sel_t alu_or   = 3'b110;
  localparam alu_sel_t alu_and  = 3'b111;

  // Register write-back source
  typedef enum logic [1:0] {
    wr_alu = 2'b00,
    wr_mem = 2'b01,
    wr_pc4 = 2'b10,
    wr_imm = 2'b11
  } wr_src_t;

  // Multicycle FSM states
  typedef enum logic [2:0] {
    st_fetch   = 3'd0,
    st_decode  = 3'd1,
    st_execute = 3'd2,
    st_memory  = 3'd3,
    st_halt    = 3'd4
  } core_state_t;

endpackage

// File: logic/rv_isa_pkg.sv
// RV32I instruction set encodings
package rv_isa_pkg;

  // Data and address word
  typedef logic [31:0] word_t;

  // Raw instruction word
  typedef logic [31:0] instr_t;

  // Register index
  typedef logic [4:0] reg_addr_t;

  // Instruction fields
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;

  // Major opcodes kept by the core
  localparam opcode_t op_op     = 7'b0110011;
  localparam opcode_t op_op_imm = 7'b0010011;
  localparam opcode_t op_lui    = 7'b0110111;
  localparam opcode_t op_auipc  = 7'b0010111;
  localparam opcode_t op_jal    = 7'b1101111;
  localparam opcode_t op_jalr   = 7'b1100111;
  localparam opcode_t op_branch = 7'b1100011;
  localparam opcode_t op_load   = 7'b0000011;
  localparam opcode_t op_store  = 7'b0100011;
  localparam opcode_t op_system = 7'b1110011;

  // Branch conditions
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

  // ADD and SUB share this funct3, funct7 bit 5 tells them apart
  localparam funct3_t f3_add_sub = 3'b000;

endpackage
